// File: common/tag_boot_defines.svh
// ####################################################################
// tag_boot parameters
// widths, client count and core reset depth of the bring-up block
// ####################################################################

`ifndef TAG_BOOT_DEFINES_SVH
`define TAG_BOOT_DEFINES_SVH

// client index and config payload
`define TAG_ID_W        2
`define TAG_PAYLOAD_W   16
`define TAG_NUM_CLIENTS 4

// cycles of core reset after the done strobe
`define TAG_RESET_DEPTH 3

`define CYCLE_CNT_W     32

// start bit + id + payload
`define TAG_FRAME_BITS  (1 + `TAG_ID_W + `TAG_PAYLOAD_W)

`endif

// File: common/tag_cfg_pkg.sv
// ####################################################################
// tag_cfg_pkg
// types of the serial tag line protocol
// ####################################################################

`include "tag_boot_defines.svh"

package tag_cfg_pkg;

  // index of one tag client
  typedef logic [`TAG_ID_W-1:0] tag_client_id_t;

  // config word held by a client
  typedef logic [`TAG_PAYLOAD_W-1:0] tag_payload_t;

  // one frame as the host hands it over
  // on the line: start bit, then id lsb first, then payload lsb first
  typedef struct packed {
    tag_client_id_t id;
    tag_payload_t   payload;
  } tag_frame_s;

endpackage

// File: common/boot_ctrl_pkg.sv
// ####################################################################
// boot_ctrl_pkg
// bring-up state, global cycle count and status flags
// ####################################################################

`include "tag_boot_defines.svh"

package boot_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    HOLD,
    RUN
  } boot_state_e;

  typedef logic [`CYCLE_CNT_W-1:0] cycle_count_t;

  typedef struct packed {
    logic busy;        // frame on the tag line
    logic tag_done;
    logic core_reset;
    logic err;         // sticky, a strobe was lost
  } boot_status_s;

endpackage

// File: hw/tag_boot/tag_boot_fsm.sv
// ####################################################################
// tag_boot_fsm
// steps idle, shift, reset hold and run; takes host strobes and
// keeps the sticky drop flag
// ####################################################################

`include "tag_boot_defines.svh"

module tag_boot_fsm (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        frame_valid_i,
  input  tag_cfg_pkg::tag_frame_s     frame_i,
  input  logic                        prog_done_i,
  input  logic                        frame_end_i,
  input  logic                        hold_end_i,
  output logic                        shift_start_o,
  output tag_cfg_pkg::tag_frame_s     shift_frame_o,
  output logic                        hold_start_o,
  output logic                        run_o,
  output boot_ctrl_pkg::boot_status_s status_o
);
  import boot_ctrl_pkg::*;

  boot_state_e state_q, state_d;
  logic        tag_done_q;
  logic        run_q;
  logic        err_q;
  logic        take_frame; // frames go out in idle and in run
  logic        drop;

  assign take_frame    = (state_q == IDLE) || (state_q == RUN);
  assign shift_start_o = frame_valid_i && take_frame;
  assign shift_frame_o = frame_i;
  assign hold_start_o  = prog_done_i && !frame_valid_i && (state_q == IDLE);

  // lost strobes, a done that loses to a frame counts too
  assign drop = ((frame_valid_i || prog_done_i) && ((state_q == SHIFT) || (state_q == HOLD)))
              || (frame_valid_i && prog_done_i && (state_q == IDLE));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (shift_start_o) state_d = SHIFT;
        else if (hold_start_o) state_d = HOLD;
      end
      SHIFT: begin
        if (frame_end_i) state_d = run_q ? RUN : IDLE; // back where we came from
      end
      HOLD: begin
        if (hold_end_i) state_d = RUN;
      end
      RUN: begin
        if (shift_start_o) state_d = SHIFT;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      tag_done_q <= 1'b0;
      run_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (hold_start_o) tag_done_q <= 1'b1;
      if ((state_q == HOLD) && hold_end_i) run_q <= 1'b1; // never drops again
      if (drop) err_q <= 1'b1;
    end
  end

  assign run_o = run_q;

  assign status_o.busy       = (state_q == SHIFT);
  assign status_o.tag_done   = tag_done_q;
  assign status_o.core_reset = ~run_q;
  assign status_o.err        = err_q;

endmodule

// File: hw/tag_boot/tag_shifter.sv
// ####################################################################
// tag_shifter
// sends one frame on the tag line, one bit per cycle
// ####################################################################

`include "tag_boot_defines.svh"

module tag_shifter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    start_i,
  input  tag_cfg_pkg::tag_frame_s frame_i,
  output logic                    tag_line_o
);

  logic [`TAG_FRAME_BITS-1:0] sreg_q;
  logic [`TAG_FRAME_BITS-1:0] frame_bits;

  // bit 0 leaves first
  assign frame_bits = {frame_i.payload, frame_i.id, 1'b1};

  // zeros fill in from the top, so the line
  // falls back to idle after the last payload bit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sreg_q <= '0;
    end else if (start_i) begin
      sreg_q <= frame_bits;
    end else begin
      sreg_q <= {1'b0, sreg_q[`TAG_FRAME_BITS-1:1]};
    end
  end

  assign tag_line_o = sreg_q[0];

endmodule

// File: hw/tag_boot/tag_client.sv
// ####################################################################
// tag_client
// receives frames off the tag line, keeps payloads sent to its index
// ####################################################################

`include "tag_boot_defines.svh"

module tag_client #(
  parameter tag_cfg_pkg::tag_client_id_t client_id_p = '0
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      tag_line_i,
  output tag_cfg_pkg::tag_payload_t payload_o
);
  import tag_cfg_pkg::*;

  localparam int body_w_lp = `TAG_ID_W + `TAG_PAYLOAD_W; // bits after the start bit
  localparam int cnt_w_lp  = $clog2(body_w_lp);

  logic [body_w_lp-1:0] sreg_q;
  logic [cnt_w_lp-1:0]  cnt_q;
  logic                 active_q;
  logic                 full_q;   // whole frame in, latch next cycle
  tag_client_id_t       rx_id;
  tag_payload_t         rx_payload;
  tag_payload_t         payload_q;

  // first bit in ends up at bit 0
  assign rx_id      = sreg_q[`TAG_ID_W-1:0];
  assign rx_payload = sreg_q[body_w_lp-1:`TAG_ID_W];

  always_ff @(posedge clk_i) begin
    if (active_q) sreg_q <= {tag_line_i, sreg_q[body_w_lp-1:1]};
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q  <= 1'b0;
      cnt_q     <= '0;
      full_q    <= 1'b0;
      payload_q <= '0;
    end else begin
      full_q <= 1'b0;
      if (!active_q && tag_line_i) begin // start bit
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == cnt_w_lp'(body_w_lp - 1)) begin
          active_q <= 1'b0;
          full_q   <= 1'b1;
        end
      end
      if (full_q && (rx_id == client_id_p)) payload_q <= rx_payload;
    end
  end

  assign payload_o = payload_q;

endmodule

// File: hw/tag_boot/boot_timer.sv
// ####################################################################
// boot_timer
// frame bit count, core reset hold count and the global cycle counter
// ####################################################################

`include "tag_boot_defines.svh"

module boot_timer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        bit_cnt_clr_i,
  input  logic                        hold_start_i,
  input  logic                        run_i,
  output logic                        frame_end_o,
  output logic                        hold_end_o,
  output boot_ctrl_pkg::cycle_count_t global_ctr_o
);
  import boot_ctrl_pkg::*;

  localparam int bit_cnt_w_lp  = $clog2(`TAG_FRAME_BITS + 1);
  localparam int hold_cnt_w_lp = $clog2(`TAG_RESET_DEPTH + 1);

  logic [bit_cnt_w_lp-1:0]  bit_cnt_q;
  logic                     bit_act_q;
  logic [hold_cnt_w_lp-1:0] hold_cnt_q;
  logic                     hold_act_q;
  cycle_count_t             ctr_q;

  assign frame_end_o = bit_act_q && (bit_cnt_q == bit_cnt_w_lp'(`TAG_FRAME_BITS));
  assign hold_end_o  = hold_act_q && (hold_cnt_q == hold_cnt_w_lp'(`TAG_RESET_DEPTH));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q  <= '0;
      bit_act_q  <= 1'b0;
      hold_cnt_q <= '0;
      hold_act_q <= 1'b0;
      ctr_q      <= '0;
    end else begin
      if (bit_cnt_clr_i) begin
        bit_cnt_q <= bit_cnt_w_lp'(1); // start bit goes out this edge
        bit_act_q <= 1'b1;
      end else if (frame_end_o) begin
        bit_act_q <= 1'b0;
      end else if (bit_act_q) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end

      if (hold_start_i) begin
        hold_cnt_q <= hold_cnt_w_lp'(1); // first hold cycle starts this edge
        hold_act_q <= 1'b1;
      end else if (hold_end_o) begin
        hold_act_q <= 1'b0;
      end else if (hold_act_q) begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end

      if (run_i) ctr_q <= ctr_q + 1'b1;
    end
  end

  assign global_ctr_o = ctr_q;

endmodule

// File: hw/tag_boot_top.sv
// ####################################################################
// tag_boot_top
// host tag programming, core reset release and global cycle count
// ####################################################################

`include "tag_boot_defines.svh"

module tag_boot_top (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic                                             frame_valid_i,
  input  tag_cfg_pkg::tag_frame_s                          frame_i,
  input  logic                                             prog_done_i,
  output boot_ctrl_pkg::boot_status_s                      status_o,
  output tag_cfg_pkg::tag_payload_t [`TAG_NUM_CLIENTS-1:0] cfg_o,
  output boot_ctrl_pkg::cycle_count_t                      global_ctr_o
);
  import tag_cfg_pkg::*;

  tag_frame_s shift_frame;
  logic       shift_start;
  logic       hold_start;
  logic       run;
  logic       frame_end;
  logic       hold_end;
  logic       tag_line;

  tag_boot_fsm fsm (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.frame_valid_i(frame_valid_i)
    ,.frame_i(frame_i)
    ,.prog_done_i(prog_done_i)
    ,.frame_end_i(frame_end)
    ,.hold_end_i(hold_end)
    ,.shift_start_o(shift_start)
    ,.shift_frame_o(shift_frame)
    ,.hold_start_o(hold_start)
    ,.run_o(run)
    ,.status_o(status_o)
  );

  // the bit counter restarts with every frame sent
  boot_timer timer (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.bit_cnt_clr_i(shift_start)
    ,.hold_start_i(hold_start)
    ,.run_i(run)
    ,.frame_end_o(frame_end)
    ,.hold_end_o(hold_end)
    ,.global_ctr_o(global_ctr_o)
  );

  tag_shifter shifter (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.start_i(shift_start)
    ,.frame_i(shift_frame)
    ,.tag_line_o(tag_line)
  );

  for (genvar i = 0; i < `TAG_NUM_CLIENTS; i++) begin : g_client
    tag_client #(
      .client_id_p(tag_client_id_t'(i))
    ) client (
      .clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.tag_line_i(tag_line)
      ,.payload_o(cfg_o[i])
    );
  end

endmodule

// File: test/tb_tag_boot.sv
// ####################################################################
// tb_tag_boot
// directed tests of tag programming, core reset release and run mode
// ####################################################################

`include "tag_boot_defines.svh"

module tb_tag_boot;
  timeunit 1ns;
  timeprecision 1ps;
  import tag_cfg_pkg::*;
  import boot_ctrl_pkg::*;

  localparam int timeout_lp = 200; // cycles per wait

  logic                                clk_i;
  logic                                arst_n_i;
  logic                                frame_valid_i;
  tag_frame_s                          frame_i;
  logic                                prog_done_i;
  boot_status_s                        status_o;
  tag_payload_t [`TAG_NUM_CLIENTS-1:0] cfg_o;
  cycle_count_t                        global_ctr_o;

  tag_payload_t model_cfg [`TAG_NUM_CLIENTS]; // last payload per index
  logic         exp_done;
  logic         exp_run;
  logic         exp_err;
  logic [31:0]  rng;
  int unsigned  edge_cnt = 0;
  int unsigned  release_edge;
  string        test_name;

  tag_boot_top DUT (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.frame_valid_i(frame_valid_i)
    ,.frame_i(frame_i)
    ,.prog_done_i(prog_done_i)
    ,.status_o(status_o)
    ,.cfg_o(cfg_o)
    ,.global_ctr_o(global_ctr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic tag_frame_s random_frame();
    tag_frame_s f;
    rng = xorshift(rng);
    f.id      = rng[`TAG_ID_W-1:0];
    f.payload = rng[31 -: `TAG_PAYLOAD_W];
    return f;
  endfunction

  function automatic boot_status_s exp_status(input logic busy);
    boot_status_s s;
    s.busy       = busy;
    s.tag_done   = exp_done;
    s.core_reset = !exp_run;
    s.err        = exp_err;
    return s;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped in %s", test_name);
  endtask

  task automatic check_payload(input string what, input tag_payload_t exp,
                               input tag_payload_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_status(input string what, input boot_status_s exp,
                              input boot_status_s act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input cycle_count_t exp,
                             input cycle_count_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic verify_cfg();
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++) begin
      check_payload($sformatf("cfg_o[%0d]", i), model_cfg[i], cfg_o[i]);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (status_o.busy) begin
      if (n == timeout_lp) begin
        $display("busy did not drop within %0d cycles in %s", timeout_lp, test_name);
        abort_run();
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic strobe_frame(input tag_frame_s f);
    @(posedge clk_i);
    frame_valid_i <= 1'b1;
    frame_i       <= f;
    @(posedge clk_i);
    frame_valid_i <= 1'b0;
  endtask

  task automatic run_frame(input tag_frame_s f);
    strobe_frame(f);
    @(negedge clk_i);
    check_status("status after strobe", exp_status(1'b1), status_o);
    wait_idle();
    @(negedge clk_i); // client latches one cycle behind busy
    model_cfg[f.id] = f.payload;
    verify_cfg();
  endtask

  task automatic test_reset_state();
    test_name = "test_reset_state";
    @(negedge clk_i);
    check_status("status", exp_status(1'b0), status_o);
    verify_cfg();
    check_count("global_ctr_o", '0, global_ctr_o);
  endtask

  task automatic test_single_frame();
    test_name = "test_single_frame";
    run_frame(random_frame());
  endtask

  task automatic test_all_clients();
    tag_frame_s f;
    test_name = "test_all_clients";
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++) begin
      f    = random_frame();
      f.id = tag_client_id_t'(i);
      run_frame(f);
    end
    run_frame(random_frame()); // rewrites an index already loaded
  endtask

  task automatic test_drop_while_busy();
    tag_frame_s first;
    tag_frame_s second;
    tag_payload_t old;
    test_name = "test_drop_while_busy";
    first  = random_frame();
    second = random_frame();
    old    = (second.id == first.id) ? first.payload : model_cfg[second.id];
    if (second.payload == old) second.payload = ~second.payload; // keep the drop visible
    @(posedge clk_i);
    frame_valid_i <= 1'b1;
    frame_i       <= first;
    @(posedge clk_i);
    frame_i <= second;
    @(posedge clk_i);
    frame_valid_i <= 1'b0;
    prog_done_i   <= 1'b1; // done while shifting is lost too
    @(posedge clk_i);
    prog_done_i <= 1'b0;
    exp_err = 1'b1;
    @(negedge clk_i);
    check_status("status after drop", exp_status(1'b1), status_o);
    wait_idle();
    @(negedge clk_i);
    model_cfg[first.id] = first.payload;
    verify_cfg();
  endtask

  task automatic test_release();
    int n;
    test_name = "test_release";
    @(posedge clk_i);
    prog_done_i <= 1'b1;
    @(posedge clk_i);
    prog_done_i <= 1'b0;
    exp_done = 1'b1;
    @(negedge clk_i);
    check_status("status after done", exp_status(1'b0), status_o);
    n = 0;
    while (status_o.core_reset) begin
      if (n == timeout_lp) begin
        $display("core reset not released within %0d cycles in %s", timeout_lp, test_name);
        abort_run();
      end
      @(negedge clk_i);
      n++;
    end
    release_edge = edge_cnt;
    exp_run = 1'b1;
    // the negedge before the loop is already one cycle after the strobe
    check_count("reset hold cycles", cycle_count_t'(`TAG_RESET_DEPTH + 1), cycle_count_t'(n + 1));
    check_status("status in run", exp_status(1'b0), status_o);
    check_count("global_ctr_o at release", '0, global_ctr_o);
    repeat (7) @(negedge clk_i);
    check_count("global_ctr_o", cycle_count_t'(edge_cnt - release_edge), global_ctr_o);
  endtask

  task automatic test_run_reconfig();
    test_name = "test_run_reconfig";
    run_frame(random_frame());
    check_status("status back in run", exp_status(1'b0), status_o);
    check_count("global_ctr_o", cycle_count_t'(edge_cnt - release_edge), global_ctr_o);
  endtask

  initial begin
    arst_n_i      = 1'b0;
    frame_valid_i = 1'b0;
    frame_i       = '0;
    prog_done_i   = 1'b0;
    exp_done      = 1'b0;
    exp_run       = 1'b0;
    exp_err       = 1'b0;
    rng           = 32'h18c9;
    test_name     = "reset";
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++) model_cfg[i] = '0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_reset_state();
    test_single_frame();
    test_all_clients();
    test_drop_while_busy();
    test_release();
    test_run_reconfig();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tag_boot.f
+incdir+common
common/tag_cfg_pkg.sv
common/boot_ctrl_pkg.sv
hw/tag_boot/tag_boot_fsm.sv
hw/tag_boot/tag_shifter.sv
hw/tag_boot/tag_client.sv
hw/tag_boot/boot_timer.sv
hw/tag_boot_top.sv
test/tb_tag_boot.sv

// File: Bender.yml
package:
  name: tag_boot

sources:
  - include_dirs:
      - common
    files:
      - common/tag_cfg_pkg.sv
      - common/boot_ctrl_pkg.sv
      - hw/tag_boot/tag_boot_fsm.sv
      - hw/tag_boot/tag_shifter.sv
      - hw/tag_boot/tag_client.sv
      - hw/tag_boot/boot_timer.sv
      - hw/tag_boot_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_tag_boot.sv
